/* serial_pkg.sv */
package serial_pkg;

    // UART bit period in clock cycles, kept short for simulation
    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

    // Wishbone register map
    localparam int ADDR_W = 2;

    // Write starts write-then-read, read returns last reply
    localparam logic [ADDR_W-1:0] ADDR_DATA   = 2'd0;
    // Bit 0 starts a read-only transaction
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 2'd1;
    // Bit 0 busy, bit 1 reply valid
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd2;

    // Transaction engine states
    typedef enum logic [1:0] {
        idle,
        write_char,
        read_char
    } sr_state_t;

endpackage

/* serial_if.sv */
`timescale 1ns/10ps

interface serial_if;

    // Command side, driven by the register decoder
    logic [7:0] tx_data;
    logic       wr;
    logic       rd;

    // Engine status and reply
    logic       busy;
    logic       valid;
    logic [7:0] rx_data;

    modport host (
        output tx_data, wr, rd,
        input  busy, valid, rx_data
    );

    modport engine (
        input  tx_data, wr, rd,
        output busy, valid, rx_data
    );

endinterface

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx import serial_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_wr_strobe,
    output logic       tx_busy,
    output logic       txd
);

    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    // Data bits followed by the stop bit
    logic [8:0]           tx_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_wr_strobe) begin
                // Start bit goes out right away
                tx_busy <= 1'b1;
                txd     <= 1'b0;
                clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= '0;
            end
        end else if (clk_cnt != '0) begin
            clk_cnt <= clk_cnt - 1'b1;
        end else begin
            clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
            if (bit_cnt == 4'd9) begin
                // Stop bit has run its full period
                tx_busy <= 1'b0;
            end else begin
                txd     <= tx_shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Shift register, LSB first, idle level shifted in behind
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_wr_strobe) begin
            tx_shift <= {1'b1, tx_data};
        end else if (tx_busy && clk_cnt == '0 && bit_cnt != 4'd9) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

endmodule

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx import serial_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic       rx_rd_strobe
);

    logic                 rxd_meta;
    logic                 rxd_sync;
    logic                 rxd_prev;
    logic                 active;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_idx;
    logic [7:0]           rx_shift;
    logic                 sample;

    // Two-flop synchronizer, third stage for edge detect
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // Middle of the current bit period
    assign sample = active && (clk_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_rd_strobe) begin
                rx_valid <= 1'b0;
            end
            if (!active) begin
                if (rxd_prev && !rxd_sync) begin
                    // Falling edge of start bit, wait half a period
                    active  <= 1'b1;
                    clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (!sample) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rxd_sync) begin
                    // Line back high, only a glitch
                    active <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    active <= 1'b0;
                    // Frame with a low stop bit is dropped
                    if (rxd_sync) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            rx_shift <= {rxd_sync, rx_shift[7:1]};
        end
        if (sample && bit_idx == 4'd9 && rxd_sync) begin
            rx_data <= rx_shift;
        end
    end

endmodule

/* send_recv.sv */
`timescale 1ns/10ps

module send_recv import serial_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    serial_if.engine   cmd,
    output logic [7:0] tx_data,
    output logic       tx_wr_strobe,
    input  logic       tx_busy,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_rd_strobe
);

    sr_state_t  state;
    logic [7:0] tx_char;

    assign cmd.busy = (state != idle);
    assign tx_data  = tx_char;

    // Strobes fire in the cycle the engine leaves its wait state
    assign tx_wr_strobe = (state == write_char) && !tx_busy;
    assign rx_rd_strobe = (state == read_char) && rx_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            cmd.valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd.wr) begin
                        state     <= write_char;
                        cmd.valid <= 1'b0;
                    end else if (cmd.rd) begin
                        state     <= read_char;
                        cmd.valid <= 1'b0;
                    end
                end
                write_char: begin
                    if (!tx_busy) begin
                        state <= read_char;
                    end
                end
                read_char: begin
                    if (rx_valid) begin
                        state     <= idle;
                        cmd.valid <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Outgoing character and reply register
    always_ff @(posedge clk) begin
        if (state == idle && cmd.wr) begin
            tx_char <= cmd.tx_data;
        end
        if (rx_rd_strobe) begin
            cmd.rx_data <= rx_data;
        end
    end

endmodule

/* serial_wb_decode.sv */
`timescale 1ns/10ps

module serial_wb_decode import serial_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] adr,
    input  logic [7:0]        dat_i,
    output logic [7:0]        dat_o,
    input  logic              we,
    input  logic              stb,
    input  logic              cyc,
    output logic              ack,
    serial_if.host            cmd
);

    logic access;
    logic cmd_write;
    logic accept;
    logic data_write;
    logic ctrl_write;

    // New bus cycle, not yet acknowledged
    assign access    = stb && cyc && !ack;
    assign cmd_write = we && (adr == ADDR_DATA || adr == ADDR_CTRL);

    // Command writes wait here until the engine is free
    assign accept     = access && !(cmd_write && cmd.busy);
    assign data_write = accept && we && (adr == ADDR_DATA);
    assign ctrl_write = accept && we && (adr == ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            cmd.wr <= 1'b0;
            cmd.rd <= 1'b0;
        end else begin
            ack    <= accept;
            cmd.wr <= data_write;
            cmd.rd <= ctrl_write && dat_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (data_write) begin
            cmd.tx_data <= dat_i;
        end
        if (accept && !we) begin
            case (adr)
                ADDR_DATA:   dat_o <= cmd.rx_data;
                ADDR_STATUS: dat_o <= {6'b0, cmd.valid, cmd.busy};
                default:     dat_o <= 8'h00;
            endcase
        end
    end

endmodule

/* serial_port_top.sv */
`timescale 1ns/10ps

module serial_port_top import serial_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [7:0]        wb_dat_i,
    output logic [7:0]        wb_dat_o,
    input  logic              wb_we,
    input  logic              wb_stb,
    input  logic              wb_cyc,
    output logic              wb_ack,
    output logic              uart_txd,
    input  logic              uart_rxd
);

    serial_if cmd_if ();

    logic [7:0] tx_data;
    logic       tx_wr_strobe;
    logic       tx_busy;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_rd_strobe;

    serial_wb_decode serial_wb_decode_i (
        .clk   (clk),
        .reset (reset),
        .adr   (wb_adr),
        .dat_i (wb_dat_i),
        .dat_o (wb_dat_o),
        .we    (wb_we),
        .stb   (wb_stb),
        .cyc   (wb_cyc),
        .ack   (wb_ack),
        .cmd   (cmd_if.host)
    );

    send_recv send_recv_i (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd_if.engine),
        .tx_data      (tx_data),
        .tx_wr_strobe (tx_wr_strobe),
        .tx_busy      (tx_busy),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_rd_strobe (rx_rd_strobe)
    );

    uart_tx uart_tx_i (
        .clk          (clk),
        .reset        (reset),
        .tx_data      (tx_data),
        .tx_wr_strobe (tx_wr_strobe),
        .tx_busy      (tx_busy),
        .txd          (uart_txd)
    );

    uart_rx uart_rx_i (
        .clk          (clk),
        .reset        (reset),
        .rxd          (uart_rxd),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_rd_strobe (rx_rd_strobe)
    );

endmodule

/* serial_port_sva.sv */
`timescale 1ns/10ps

module serial_port_sva import serial_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      wb_stb,
    input logic      wb_cyc,
    input logic      wb_ack,
    input logic      uart_txd,
    input logic      tx_busy,
    input sr_state_t state
);

    ack_needs_strobe: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_stb && wb_cyc))
        else $error("wb_ack high without wb_stb and wb_cyc");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    // Line idles high whenever nothing is being sent
    txd_idle_high: assert property (@(posedge clk) disable iff (reset)
        (state == idle && !tx_busy) |-> uart_txd)
        else $error("uart_txd low while the engine and transmitter are idle");

endmodule

bind serial_port_top serial_port_sva serial_port_sva_i (
    .clk      (clk),
    .reset    (reset),
    .wb_stb   (wb_stb),
    .wb_cyc   (wb_cyc),
    .wb_ack   (wb_ack),
    .uart_txd (uart_txd),
    .tx_busy  (tx_busy),
    .state    (send_recv_i.state)
);

/* serial_port_tb.sv */
`timescale 1ns/10ps

module serial_port_tb import serial_pkg::*; ();

    logic              clk;
    logic              reset;
    logic [ADDR_W-1:0] wb_adr;
    logic [7:0]        wb_dat_i;
    logic [7:0]        wb_dat_o;
    logic              wb_we;
    logic              wb_stb;
    logic              wb_cyc;
    logic              wb_ack;
    logic              uart_txd;
    logic              uart_rxd;
    // Receive line source and transmit line monitor
    logic              loopback;
    logic              serial_line;
    logic              txd_watch;

    assign uart_rxd = loopback ? uart_txd : serial_line;

    serial_port_top serial_port_top_i (
        .clk      (clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .uart_txd (uart_txd),
        .uart_rxd (uart_rxd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp)
            else report_failure($sformatf("MISMATCH %s: got 0x%02h, expected 0x%02h",
                                          name, got, exp));
    endtask

    // Transmit line must stay high during read-only transactions
    always @(negedge clk) begin
        if (txd_watch) begin
            check_value("uart_txd", {7'b0, uart_txd}, 8'h01);
        end
    end

    task automatic wb_access(input logic [ADDR_W-1:0] adr, input logic we,
                             input logic [7:0] wdata, output logic [7:0] rdata,
                             output int wait_cycles);
        @(negedge clk);
        wb_adr      = adr;
        wb_we       = we;
        wb_dat_i    = wdata;
        wb_stb      = 1'b1;
        wb_cyc      = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 40 * CLKS_PER_BIT) begin
                report_failure("timeout waiting for wb_ack");
            end
        end while (!wb_ack);
        rdata = wb_dat_o;
        // Strobe stays up across the edge that samples ack
        @(negedge clk);
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [7:0] data,
                            output int wait_cycles);
        logic [7:0] unused_data;
        wb_access(adr, 1'b1, data, unused_data, wait_cycles);
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [7:0] data);
        int wait_cycles;
        wb_access(adr, 1'b0, 8'h00, data, wait_cycles);
    endtask

    task automatic wait_idle();
        logic [7:0] status;
        int         polls;
        polls = 0;
        do begin
            wb_read(ADDR_STATUS, status);
            polls++;
            if (polls > 100) begin
                report_failure("timeout waiting for the busy flag to clear");
            end
        end while (status[0]);
    endtask

    // 8N1 frame, then one bit period of idle line
    task automatic send_serial_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            serial_line = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
        @(negedge clk);
        serial_line = 1'b1;
        repeat (CLKS_PER_BIT - 1) @(negedge clk);
    endtask

    task automatic echo_byte(input logic [7:0] value);
        logic [7:0] data;
        int         wait_cycles;
        wb_write(ADDR_DATA, value, wait_cycles);
        wait_idle();
        wb_read(ADDR_STATUS, data);
        check_value("wb_dat_o (status)", data, 8'h02);
        wb_read(ADDR_DATA, data);
        check_value("wb_dat_o (data)", data, value);
    endtask

    task automatic idle_after_reset();
        logic [7:0] data;
        wb_read(ADDR_STATUS, data);
        check_value("wb_dat_o (status)", data, 8'h00);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("uart_txd", {7'b0, uart_txd}, 8'h01);
        end
    endtask

    task automatic random_echo();
        repeat (20) echo_byte(8'($urandom));
    endtask

    task automatic read_only_receive();
        logic [7:0] value;
        logic [7:0] data;
        int         wait_cycles;
        value     = 8'($urandom);
        loopback  = 1'b0;
        txd_watch = 1'b1;
        wb_write(ADDR_CTRL, 8'h01, wait_cycles);
        send_serial_byte(value, 1'b1);
        wait_idle();
        txd_watch = 1'b0;
        wb_read(ADDR_DATA, data);
        check_value("wb_dat_o (data)", data, value);
    endtask

    task automatic write_back_pressure();
        logic [7:0] first;
        logic [7:0] second;
        logic [7:0] data;
        int         wait_cycles;
        first    = 8'($urandom);
        second   = ~first;
        loopback = 1'b1;
        wb_write(ADDR_DATA, first, wait_cycles);
        // Engine is busy now, this write must be held off
        wb_write(ADDR_DATA, second, wait_cycles);
        assert (wait_cycles > 9 * CLKS_PER_BIT)
            else report_failure($sformatf(
                "second write acknowledged after %0d cycles, before the first finished",
                wait_cycles));
        wb_read(ADDR_DATA, data);
        check_value("wb_dat_o (first reply)", data, first);
        wait_idle();
        wb_read(ADDR_DATA, data);
        check_value("wb_dat_o (second reply)", data, second);
    endtask

    task automatic bad_stop_bit_discard();
        logic [7:0] bad;
        logic [7:0] data;
        int         wait_cycles;
        bad       = 8'($urandom);
        loopback  = 1'b0;
        txd_watch = 1'b1;
        wb_write(ADDR_CTRL, 8'h01, wait_cycles);
        send_serial_byte(bad, 1'b0);
        // Still waiting, nothing stored
        wb_read(ADDR_STATUS, data);
        check_value("wb_dat_o (status)", data, 8'h01);
        send_serial_byte(~bad, 1'b1);
        wait_idle();
        txd_watch = 1'b0;
        wb_read(ADDR_DATA, data);
        check_value("wb_dat_o (data)", data, ~bad);
    endtask

    initial begin
        void'($urandom(46787));
        reset       = 1'b1;
        wb_adr      = '0;
        wb_dat_i    = 8'h00;
        wb_we       = 1'b0;
        wb_stb      = 1'b0;
        wb_cyc      = 1'b0;
        loopback    = 1'b1;
        serial_line = 1'b1;
        txd_watch   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        echo_byte(8'hA5);
        random_echo();
        read_only_receive();
        write_back_pressure();
        bad_stop_bit_discard();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* files.f */
serial_pkg.sv
serial_if.sv
uart_tx.sv
uart_rx.sv
send_recv.sv
serial_wb_decode.sv
serial_port_top.sv
serial_port_sva.sv
serial_port_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the serial port testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f \
        --top-module serial_port_tb -o serial_port_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/serial_port_sim; then
    echo "Simulation failed"
    exit 1
fi

exit 0
